/* Makefile */
# Verilator build and run for the FP32 multiplier testbench

VERILATOR ?= verilator
TOP       ?= fp32_mul_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

SOURCES := $(wildcard include/*.svh logic/*.sv testbench/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

# Judges the log of the last run
check:
	@test -f $(LOG) || (echo "No log found, run the simulation first"; exit 1)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* all.f */
+incdir+include
logic/fp32_pkg.sv
logic/fp32_decode.sv
logic/fp32_sig_mul.sv
logic/fp32_norm_round.sv
logic/fp32_mul.sv
testbench/fp32_mul_props.sv
testbench/fp32_mul_tb.sv

/* include/fp32_consts.svh */
`ifndef FP32_CONSTS_SVH
`define FP32_CONSTS_SVH

// Field widths of the FP32 word
`define FP32_WORD_BITS  32
`define FP32_EXP_BITS   8
`define FP32_FRAC_BITS  23

// Exponent bias and the all-ones exponent used for Inf and NaN
`define FP32_BIAS       127
`define FP32_EXP_MAX    255

// Canonical quiet NaN
`define FP32_QNAN       32'h7FC0_0000

// Latency from accepting a pair to its result
`define FP32_PIPE_DEPTH 3

`endif

/* logic/fp32_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp32_consts.svh"

module fp32_decode import fp32_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  fp32_word_t  a,
    input  fp32_word_t  b,
    input  logic        in_valid,
    output logic        s1_valid,
    output logic        a_sign,
    output logic        b_sign,
    output fp32_exp_t   a_exp,
    output fp32_exp_t   b_exp,
    output fp32_sig_t   a_sig,
    output fp32_sig_t   b_sig,
    output fp32_class_t a_cls,
    output fp32_class_t b_cls
);

    // Zero exponent field means zero here, subnormals are not kept
    function automatic fp32_class_t classify(input fp32_exp_t e, input fp32_frac_t f);
        if (e == '0)
            return cls_zero;
        else if (e == fp32_exp_t'(`FP32_EXP_MAX))
            return (f == '0) ? cls_inf : cls_nan;
        else
            return cls_normal;
    endfunction

    fp32_class_t a_cls_d;
    fp32_class_t b_cls_d;

    assign a_cls_d = classify(a[30:23], a[22:0]);
    assign b_cls_d = classify(b[30:23], b[22:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s1_valid <= 1'b0;
        else
            s1_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            a_sign <= a[31];
            b_sign <= b[31];
            a_exp  <= a[30:23];
            b_exp  <= b[30:23];
            a_sig  <= {a_cls_d == cls_normal, a[22:0]};    // Hidden bit only for normals
            b_sig  <= {b_cls_d == cls_normal, b[22:0]};
            a_cls  <= a_cls_d;
            b_cls  <= b_cls_d;
        end
    end

endmodule

`default_nettype wire

/* logic/fp32_mul.sv */
`timescale 1ns/1ps
`default_nettype none

module fp32_mul import fp32_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  fp32_word_t a,
    input  fp32_word_t b,
    input  logic       in_valid,
    output logic       out_valid,
    output fp32_word_t result
);

    // Decode to multiply
    logic        s1_valid;
    logic        a_sign;
    logic        b_sign;
    fp32_exp_t   a_exp;
    fp32_exp_t   b_exp;
    fp32_sig_t   a_sig;
    fp32_sig_t   b_sig;
    fp32_class_t a_cls;
    fp32_class_t b_cls;

    // Multiply to round
    logic        s2_valid;
    logic        s2_sign;
    fp32_wexp_t  s2_exp;
    fp32_prod_t  s2_prod;
    logic        s2_special;
    fp32_word_t  s2_special_word;

    fp32_decode i_decode (.clk, .rst_n, .a, .b, .in_valid, .s1_valid,
        .a_sign, .b_sign, .a_exp, .b_exp, .a_sig, .b_sig, .a_cls, .b_cls);

    fp32_sig_mul i_sig_mul (.clk, .rst_n, .s1_valid,
        .a_sign, .b_sign, .a_exp, .b_exp, .a_sig, .b_sig, .a_cls, .b_cls,
        .s2_valid, .s2_sign, .s2_exp, .s2_prod, .s2_special, .s2_special_word);

    fp32_norm_round i_norm_round (.clk, .rst_n, .s2_valid, .s2_sign, .s2_exp,
        .s2_prod, .s2_special, .s2_special_word, .out_valid, .result);

endmodule

`default_nettype wire

/* logic/fp32_norm_round.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp32_consts.svh"

module fp32_norm_round import fp32_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       s2_valid,
    input  logic       s2_sign,
    input  fp32_wexp_t s2_exp,
    input  fp32_prod_t s2_prod,
    input  logic       s2_special,
    input  fp32_word_t s2_special_word,
    output logic       out_valid,
    output fp32_word_t result
);

    fp32_prod_t               norm_prod;
    fp32_wexp_t               norm_exp;
    fp32_frac_t               frac_trunc;
    logic                     guard_bit;
    logic                     sticky_bit;
    logic                     round_up;
    logic [`FP32_FRAC_BITS:0] frac_sum;
    fp32_wexp_t               final_exp;
    logic                     overflow;
    logic                     underflow;
    fp32_word_t               result_d;

    // Product of two values in [1,2) lies in [1,4), so one shift is enough
    always_comb begin
        if (s2_prod[47]) begin
            norm_prod = s2_prod >> 1;
            norm_exp  = s2_exp + fp32_wexp_t'(1);
        end else begin
            norm_prod = s2_prod;
            norm_exp  = s2_exp;
        end
    end

    // Leading one now at bit 46
    assign frac_trunc = norm_prod[45:23];
    assign guard_bit  = norm_prod[22];
    assign sticky_bit = (|norm_prod[21:0]) | s2_prod[0];    // Bit 0 still counts after the shift

    // Nearest even: above half, or exactly half with odd LSB
    assign round_up = guard_bit & (sticky_bit | frac_trunc[0]);

    assign frac_sum = {1'b0, frac_trunc} + {{`FP32_FRAC_BITS{1'b0}}, round_up};

    // Carry out leaves a zero fraction and bumps the exponent
    assign final_exp = norm_exp + fp32_wexp_t'(frac_sum[`FP32_FRAC_BITS]);

    assign overflow  = final_exp >= fp32_wexp_t'(`FP32_EXP_MAX);
    assign underflow = final_exp <= fp32_wexp_t'(0);           // Flushed, no subnormals

    always_comb begin
        if (s2_special)
            result_d = s2_special_word;
        else if (overflow)
            result_d = {s2_sign, fp32_exp_t'(`FP32_EXP_MAX), fp32_frac_t'(0)};
        else if (underflow)
            result_d = {s2_sign, fp32_exp_t'(0), fp32_frac_t'(0)};
        else
            result_d = {s2_sign, final_exp[`FP32_EXP_BITS-1:0],
                        frac_sum[`FP32_FRAC_BITS-1:0]};
    end

    // Result holds its last value between outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= s2_valid;
            if (s2_valid)
                result <= result_d;
        end
    end

endmodule

`default_nettype wire

/* logic/fp32_pkg.sv */
`default_nettype none

package fp32_pkg;

    `include "fp32_consts.svh"

    typedef logic [`FP32_WORD_BITS-1:0] fp32_word_t;        // Packed sign/exp/frac word
    typedef logic [`FP32_EXP_BITS-1:0] fp32_exp_t;          // Biased exponent field
    typedef logic [`FP32_FRAC_BITS-1:0] fp32_frac_t;        // Stored fraction
    typedef logic [`FP32_FRAC_BITS:0] fp32_sig_t;           // Fraction with hidden one
    typedef logic [2*(`FP32_FRAC_BITS+1)-1:0] fp32_prod_t;  // Full significand product

    // Working exponent, wide enough for -125 .. +384 with no wrap
    typedef logic signed [`FP32_EXP_BITS+1:0] fp32_wexp_t;

    // Operand class after decode
    typedef enum logic [1:0] {
        cls_zero,
        cls_normal,
        cls_inf,
        cls_nan
    } fp32_class_t;

endpackage

`default_nettype wire

/* logic/fp32_sig_mul.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp32_consts.svh"

module fp32_sig_mul import fp32_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        s1_valid,
    input  logic        a_sign,
    input  logic        b_sign,
    input  fp32_exp_t   a_exp,
    input  fp32_exp_t   b_exp,
    input  fp32_sig_t   a_sig,
    input  fp32_sig_t   b_sig,
    input  fp32_class_t a_cls,
    input  fp32_class_t b_cls,
    output logic        s2_valid,
    output logic        s2_sign,
    output fp32_wexp_t  s2_exp,
    output fp32_prod_t  s2_prod,
    output logic        s2_special,
    output fp32_word_t  s2_special_word
);

    logic       sign_d;
    fp32_wexp_t exp_d;
    fp32_prod_t prod_d;
    logic       res_nan;
    logic       res_inf;
    logic       res_zero;
    fp32_word_t special_word_d;

    assign sign_d = a_sign ^ b_sign;

    // Biased sum minus one bias keeps the result biased
    assign exp_d = fp32_wexp_t'({2'b00, a_exp}) + fp32_wexp_t'({2'b00, b_exp})
                 - fp32_wexp_t'(`FP32_BIAS);

    assign prod_d = fp32_prod_t'(a_sig) * fp32_prod_t'(b_sig);    // 24x24 -> 48

    // NaN also covers Inf times zero
    assign res_nan  = (a_cls == cls_nan) || (b_cls == cls_nan)
                   || ((a_cls == cls_inf) && (b_cls == cls_zero))
                   || ((b_cls == cls_inf) && (a_cls == cls_zero));
    assign res_inf  = (a_cls == cls_inf) || (b_cls == cls_inf);
    assign res_zero = (a_cls == cls_zero) || (b_cls == cls_zero);

    always_comb begin
        if (res_nan)
            special_word_d = `FP32_QNAN;                            // Sign stays clear
        else if (res_inf)
            special_word_d = {sign_d, fp32_exp_t'(`FP32_EXP_MAX), fp32_frac_t'(0)};
        else
            special_word_d = {sign_d, fp32_exp_t'(0), fp32_frac_t'(0)};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            s2_valid <= 1'b0;
        else
            s2_valid <= s1_valid;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_sign         <= sign_d;
            s2_exp          <= exp_d;
            s2_prod         <= prod_d;
            s2_special      <= res_nan | res_inf | res_zero;
            s2_special_word <= special_word_d;
        end
    end

endmodule

`default_nettype wire

/* testbench/fp32_mul_props.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp32_consts.svh"

module fp32_mul_props import fp32_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       out_valid,
    input fp32_word_t result
);

    // No result may appear while reset is held
    a_idle_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high after reset");

    // Fixed latency, one result per accepted pair
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == $past(in_valid, `FP32_PIPE_DEPTH))
        else $error("out_valid does not follow in_valid by the pipeline depth");

    // Every NaN leaves as the canonical quiet NaN
    a_nan_canonical: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && result[30:23] == 8'hFF && result[22:0] != '0)
        |-> result == `FP32_QNAN)
        else $error("NaN result is not the canonical quiet NaN");

endmodule

bind fp32_mul fp32_mul_props i_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .out_valid (out_valid),
    .result    (result)
);

`default_nettype wire

/* testbench/fp32_mul_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fp32_consts.svh"

module fp32_mul_tb import fp32_pkg::*; ();

    localparam int CLK_PERIOD     = 100;
    localparam int RST_CYCLES     = 16;
    localparam int DIRECTED_PAIRS = 31;
    localparam int STREAM_PAIRS   = 200;
    localparam int NUM_TESTS      = 6;

    logic       clk;
    logic       rst_n;
    fp32_word_t a;
    fp32_word_t b;
    logic       in_valid;
    logic       out_valid;
    fp32_word_t result;

    fp32_word_t  exp_q[$];                  // Expected words in issue order
    logic [`FP32_PIPE_DEPTH-1:0] vpipe = '0;    // in_valid seen at past falling edges
    logic [31:0] lfsr_state = 32'h47E5_975B;
    string       test_name = "none";
    int          checks = 0;
    int          errors = 0;

    fp32_mul i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .a         (a),
        .b         (b),
        .in_valid  (in_valid),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois LFSR, taps 32 30 26 25
    function automatic logic lfsr_bit();
        logic out_b;
        out_b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_b)
            lfsr_state = lfsr_state ^ 32'hA300_0000;
        return out_b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    // Exponent kept near the middle so most products stay in range
    function automatic fp32_word_t rand_operand();
        logic [31:0] sign_r;
        logic [31:0] exp_r;
        logic [31:0] frac_r;
        sign_r = rand_bits(1);
        exp_r  = rand_bits(7) + 32'd64;
        frac_r = rand_bits(23);
        return {sign_r[0], exp_r[7:0], frac_r[22:0]};
    endfunction

    // Reference multiply on integer fields, zero exponent treated as zero
    function automatic fp32_word_t model_mul(input fp32_word_t x, input fp32_word_t y);
        int          ex;
        int          ey;
        int          e;
        logic        sgn;
        logic        x_zero;
        logic        y_zero;
        logic        x_inf;
        logic        y_inf;
        logic        x_nan;
        logic        y_nan;
        logic [47:0] p;
        logic [22:0] frac;
        logic        guard;
        logic        sticky;
        ex = int'(x[30:23]);
        ey = int'(y[30:23]);
        sgn = x[31] ^ y[31];
        x_zero = (ex == 0);
        y_zero = (ey == 0);
        x_inf = (ex == 255) && (x[22:0] == '0);
        y_inf = (ey == 255) && (y[22:0] == '0);
        x_nan = (ex == 255) && (x[22:0] != '0);
        y_nan = (ey == 255) && (y[22:0] != '0);
        if (x_nan || y_nan || (x_inf && y_zero) || (y_inf && x_zero))
            return `FP32_QNAN;
        if (x_inf || y_inf)
            return {sgn, 8'hFF, 23'd0};
        if (x_zero || y_zero)
            return {sgn, 31'd0};
        p = {25'd1, x[22:0]} * {25'd1, y[22:0]};
        e = ex + ey - 127;
        if (p[47]) begin                    // Product in [2,4)
            frac   = p[46:24];
            guard  = p[23];
            sticky = |p[22:0];
            e = e + 1;
        end else begin
            frac   = p[45:23];
            guard  = p[22];
            sticky = |p[21:0];
        end
        if (guard && (sticky || frac[0])) begin
            if (&frac) begin                // Rounds up to the next power of two
                frac = '0;
                e = e + 1;
            end else begin
                frac = frac + 23'd1;
            end
        end
        if (e >= 255)
            return {sgn, 8'hFF, 23'd0};
        if (e <= 0)
            return {sgn, 31'd0};
        return {sgn, e[7:0], frac};
    endfunction

    task automatic check_word(input string name, input fp32_word_t exp_w,
                              input fp32_word_t act_w);
        checks++;
        if (exp_w !== act_w) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, exp_w, act_w);
        end
    endtask

    task automatic check_bit(input string name, input logic exp_b, input logic act_b);
        checks++;
        if (exp_b !== act_b) begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, exp_b, act_b);
        end
    endtask

    task automatic send(input fp32_word_t x, input fp32_word_t y, input fp32_word_t exp_w);
        @(posedge clk);
        a        <= x;
        b        <= y;
        in_valid <= 1'b1;
        exp_q.push_back(exp_w);
    endtask

    task automatic drain();
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
        @(negedge clk);
    endtask

    // Outputs sampled mid-cycle, away from the rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            check_bit({test_name, " latency"}, vpipe[`FP32_PIPE_DEPTH-1], out_valid);
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Result arrived with no pair outstanding in test %s", test_name);
                end else begin
                    check_word(test_name, exp_q.pop_front(), result);
                end
            end
        end
        vpipe <= {vpipe[`FP32_PIPE_DEPTH-2:0], in_valid & rst_n};
    end

    task automatic reset_state();
        test_name = "reset_state";
        @(negedge clk);
        check_bit(test_name, 1'b0, out_valid);
        check_word(test_name, '0, result);
    endtask

    task automatic special_cases();
        test_name = "special_cases";
        send(32'h7FC0_0001, 32'h3F80_0000, `FP32_QNAN);     // Quiet NaN in
        send(32'h7F80_0001, 32'h3F80_0000, `FP32_QNAN);     // Signaling NaN in
        send(32'hFFC0_0000, 32'hC000_0000, `FP32_QNAN);     // NaN sign dropped
        send(32'h7FC0_0000, 32'h7F80_0000, `FP32_QNAN);     // NaN beats Inf
        send(32'h7F80_0000, 32'h0000_0000, `FP32_QNAN);     // Inf times zero
        send(32'h8000_0000, 32'hFF80_0000, `FP32_QNAN);
        send(32'h7F80_0000, 32'h0040_0000, `FP32_QNAN);     // Subnormal acts as zero
        send(32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000);
        send(32'hFF80_0000, 32'hFF80_0000, 32'h7F80_0000);
        send(32'h8000_0000, 32'h4040_0000, 32'h8000_0000);
        send(32'h0000_0001, 32'h4000_0000, 32'h0000_0000);
        send(32'h8040_0000, 32'h3F80_0000, 32'h8000_0000);
        drain();
    endtask

    task automatic exact_products();
        test_name = "exact_products";
        send(32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000);  // 1.5 * 2.0
        send(32'hC040_0000, 32'h3F00_0000, 32'hBFC0_0000);  // -3.0 * 0.5
        send(32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000);  // Product bit 47 set
        send(32'h4040_0000, 32'h4040_0000, 32'h4110_0000);
        send(32'h3F80_0000, 32'hBF80_0000, 32'hBF80_0000);
        drain();
    endtask

    task automatic rounding();
        test_name = "rounding";
        send(32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002);  // Tie, odd LSB rounds up
        send(32'h3F80_0003, 32'h3FC0_0000, 32'h3FC0_0004);  // Tie, even LSB kept
        send(32'h3FC0_0000, 32'h3FC0_0002, 32'h4010_0002);  // Tie after the shift
        send(32'h3FFF_FFFD, 32'h3FD5_5555, 32'h4055_5553);  // Shifted-out bit breaks the tie
        send(32'h3F80_0001, 32'h3F80_0001, 32'h3F80_0002);  // Below half
        send(32'h3F84_2108, 32'h3FF8_0000, 32'h4000_0000);  // Carry into exponent
        drain();
    endtask

    task automatic range_limits();
        test_name = "range_limits";
        send(32'h7F00_0000, 32'h4000_0000, 32'h7F80_0000);
        send(32'hFF00_0000, 32'h4000_0000, 32'hFF80_0000);
        send(32'h7F00_0000, 32'h3F80_0000, 32'h7F00_0000);  // Largest exponent kept
        send(32'h7F7F_FFFF, 32'h3F80_0001, 32'h7F80_0000);
        send(32'h0080_0000, 32'h3F00_0000, 32'h0000_0000);
        send(32'h8080_0000, 32'h3F00_0000, 32'h8000_0000);
        send(32'h0080_0000, 32'h3F80_0000, 32'h0080_0000);  // Smallest normal kept
        send(32'h0D00_0000, 32'h0D00_0000, 32'h0000_0000);
        drain();
    endtask

    task automatic streaming();
        fp32_word_t x;
        fp32_word_t y;
        int         i;
        test_name = "streaming";
        for (i = 0; i < STREAM_PAIRS; i++) begin
            if (i % 8 == 0)
                x = rand_bits(32);                          // Full range now and then
            else
                x = rand_operand();
            y = rand_operand();
            send(x, y, model_mul(x, y));
        end
        drain();
    endtask

    initial begin
        #((RST_CYCLES + DIRECTED_PAIRS + STREAM_PAIRS + 8 * NUM_TESTS + 50) * CLK_PERIOD);
        $display("Timeout: the tests did not complete in the allowed time");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        a        = '0;
        b        = '0;
        in_valid = 1'b0;
        rst_n    = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        special_cases();
        exact_products();
        rounding();
        range_limits();
        streaming();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
